/* noise_filter_pkg.sv */
// fixed 320x240 frame of 4-bit RGB channels; address packs the row above the column, no runtime sizing
`default_nettype none

package noise_filter_pkg;

    // channel and frame geometry
    localparam int CHAN_W   = 4;
    localparam int NUM_CHAN = 3;                  // R, G, B
    localparam int PIX_W    = CHAN_W * NUM_CHAN;
    localparam int H_PIXELS = 320;
    localparam int V_LINES  = 240;

    // address field widths
    localparam int X_W      = 9;
    localparam int Y_W      = 8;
    localparam int ADDR_W   = X_W + Y_W;          // row in the upper bits

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [PIX_W-1:0]  pixel_t;           // red in the top bits
    typedef logic [X_W-1:0]    xpos_t;
    typedef logic [Y_W-1:0]    ypos_t;
    typedef logic [ADDR_W-1:0] pix_addr_t;

    // line buffer clear sequencer
    typedef enum logic {
        CLR_IDLE,
        CLR_RUN
    } clr_state_t;

    // input stream, one strobe per pixel
    typedef struct packed {
        logic      valid;
        logic      active;                        // inside the visible area
        pix_addr_t addr;
        pixel_t    pixel;
    } pix_stream_t;

    // output stream
    typedef struct packed {
        logic   valid;
        logic   filtered;                         // pixel went through the average
        pixel_t pixel;
    } pix_result_t;

    // request from the feeder into one lane
    typedef struct packed {
        logic  valid;
        logic  filter;                            // average with the left neighbor
        logic  store;                             // write value back at column x
        xpos_t x;
        chan_t value;
    } lane_req_t;

    // clear command, same for every lane
    typedef struct packed {
        logic  clear;
        xpos_t addr;
    } lane_clr_t;

    // registered lane result
    typedef struct packed {
        logic  valid;
        logic  filtered;
        chan_t value;
    } lane_resp_t;

endpackage

`default_nettype wire

/* pixel_frame_ctrl.sv */
// one pixel per cycle max, no stall; a vsync rise mid-clear restarts the 320-cycle wipe at column 0
`default_nettype none

module pixel_frame_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          enable,
    input  logic                          vsync,
    input  noise_filter_pkg::pix_stream_t pix_in,
    output noise_filter_pkg::lane_req_t   req [noise_filter_pkg::NUM_CHAN],
    output noise_filter_pkg::lane_clr_t   clr
);

    noise_filter_pkg::xpos_t      x_pos;
    noise_filter_pkg::ypos_t      y_pos;
    logic                         in_range;

    logic                         vsync_q;
    logic                         vsync_qq;
    logic                         vsync_rise;

    noise_filter_pkg::clr_state_t clr_state;
    noise_filter_pkg::clr_state_t clr_state_nxt;
    noise_filter_pkg::xpos_t      clr_cnt;
    noise_filter_pkg::xpos_t      clr_cnt_nxt;

    logic                         store_ok;
    logic                         valid_q;
    logic                         filter_q;
    logic                         store_q;
    noise_filter_pkg::xpos_t      x_q;
    noise_filter_pkg::pixel_t     pixel_q;

    // address split and range check
    assign x_pos    = pix_in.addr[noise_filter_pkg::X_W-1:0];
    assign y_pos    = pix_in.addr[noise_filter_pkg::ADDR_W-1:noise_filter_pkg::X_W];
    assign in_range = (x_pos < noise_filter_pkg::xpos_t'(noise_filter_pkg::H_PIXELS)) &&
                      (y_pos < noise_filter_pkg::ypos_t'(noise_filter_pkg::V_LINES));

    // vsync edge, seen one cycle after the rise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end else begin
            vsync_q  <= vsync;
            vsync_qq <= vsync_q;
        end
    end

    assign vsync_rise = vsync_q & ~vsync_qq;

    // clear sequencer, walks addr 0..319 once per rise
    always_comb begin
        clr_state_nxt = clr_state;
        clr_cnt_nxt   = clr_cnt;
        if (vsync_rise) begin
            clr_state_nxt = noise_filter_pkg::CLR_RUN;   // restart even mid-clear
            clr_cnt_nxt   = '0;
        end else if (clr_state == noise_filter_pkg::CLR_RUN) begin
            if (clr_cnt == noise_filter_pkg::xpos_t'(noise_filter_pkg::H_PIXELS - 1)) begin
                clr_state_nxt = noise_filter_pkg::CLR_IDLE;
                clr_cnt_nxt   = '0;
            end else begin
                clr_cnt_nxt = clr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr_state <= noise_filter_pkg::CLR_IDLE;
            clr_cnt   <= '0;
        end else begin
            clr_state <= clr_state_nxt;
            clr_cnt   <= clr_cnt_nxt;
        end
    end

    assign clr.clear = (clr_state == noise_filter_pkg::CLR_RUN);
    assign clr.addr  = clr_cnt;

    // gate on the next state so a registered store never overlaps a clear cycle
    assign store_ok = pix_in.valid && pix_in.active && in_range &&
                      (clr_state_nxt == noise_filter_pkg::CLR_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= 1'b0;
            filter_q <= 1'b0;
            store_q  <= 1'b0;
        end else begin
            valid_q  <= pix_in.valid;
            filter_q <= store_ok & enable;
            store_q  <= store_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_in.valid) begin
            x_q     <= x_pos;
            pixel_q <= pix_in.pixel;
        end
    end

    // one request per channel, lane 0 takes red
    always_comb begin
        for (int i = 0; i < noise_filter_pkg::NUM_CHAN; i++) begin
            req[i].valid  = valid_q;
            req[i].filter = filter_q;
            req[i].store  = store_q;
            req[i].x      = x_q;
            req[i].value  = pixel_q[noise_filter_pkg::PIX_W-1-i*noise_filter_pkg::CHAN_W
                                    -: noise_filter_pkg::CHAN_W];
        end
    end

endmodule

`default_nettype wire

/* channel_avg_lane.sv */
// line memory has no reset and holds junk until the first vsync clear; store and clear must not overlap
`default_nettype none

module channel_avg_lane (
    input  logic                         clk,
    input  logic                         arst_n,
    input  noise_filter_pkg::lane_req_t  req,
    input  noise_filter_pkg::lane_clr_t  clr,
    output noise_filter_pkg::lane_resp_t resp
);

    // last stored value per column
    noise_filter_pkg::chan_t            line_mem [noise_filter_pkg::H_PIXELS];

    noise_filter_pkg::chan_t            left_val;
    logic [noise_filter_pkg::CHAN_W:0]  pair_sum;       // one carry bit
    noise_filter_pkg::chan_t            avg_val;

    logic                               valid_q;
    logic                               filtered_q;
    noise_filter_pkg::chan_t            value_q;

    // column 0 has no left neighbor, treat it as black
    assign left_val = (req.x == '0) ? '0 : line_mem[req.x - 1'b1];

    assign pair_sum = {1'b0, req.value} + {1'b0, left_val};
    assign avg_val  = pair_sum[noise_filter_pkg::CHAN_W:1];   // floor of the mean

    // write port
    // a store lands on the same edge as the result, so the next
    // pixel in the row already reads it back
    always_ff @(posedge clk) begin
        if (clr.clear) begin
            line_mem[clr.addr] <= '0;
        end else if (req.store) begin
            line_mem[req.x] <= req.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= 1'b0;
            filtered_q <= 1'b0;
        end else begin
            valid_q    <= req.valid;
            filtered_q <= req.valid & req.filter;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            value_q <= req.filter ? avg_val : req.value;   // raw value when bypassed
        end
    end

    assign resp.valid    = valid_q;
    assign resp.filtered = filtered_q;
    assign resp.value    = value_q;

endmodule

`default_nettype wire

/* pixel_merge.sv */
// lanes run in lockstep so lane 0 status stands for the whole pixel; pixel holds between strobes
`default_nettype none

module pixel_merge (
    input  logic                          clk,
    input  logic                          arst_n,
    input  noise_filter_pkg::lane_resp_t  resp [noise_filter_pkg::NUM_CHAN],
    output noise_filter_pkg::pix_result_t pix_out
);

    logic                     any_valid;
    noise_filter_pkg::pixel_t joined;

    // channel order is R, G, B from the top bits down
    always_comb begin
        any_valid = 1'b0;
        joined    = '0;
        for (int i = 0; i < noise_filter_pkg::NUM_CHAN; i++) begin
            any_valid = any_valid | resp[i].valid;
            joined[noise_filter_pkg::PIX_W-1-i*noise_filter_pkg::CHAN_W
                   -: noise_filter_pkg::CHAN_W] = resp[i].value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_out <= '0;
        end else begin
            pix_out.valid    <= resp[0].valid;
            pix_out.filtered <= resp[0].filtered;
            if (any_valid) begin
                pix_out.pixel <= joined;   // otherwise keep the last pixel
            end
        end
    end

endmodule

`default_nettype wire

/* noise_filter_top.sv */
// fixed 3-cycle latency from pix_in.valid to pix_out.valid, no back-pressure; pulse vsync before trusting filtered output
`default_nettype none

module noise_filter_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          enable,
    input  logic                          vsync,
    input  noise_filter_pkg::pix_stream_t pix_in,
    output noise_filter_pkg::pix_result_t pix_out
);

    noise_filter_pkg::lane_req_t  lane_req  [noise_filter_pkg::NUM_CHAN];
    noise_filter_pkg::lane_resp_t lane_resp [noise_filter_pkg::NUM_CHAN];
    noise_filter_pkg::lane_clr_t  lane_clr;    // shared by all lanes

    // address decode, clear sequence, channel split
    pixel_frame_ctrl u_pixel_frame_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (enable),
        .vsync  (vsync),
        .pix_in (pix_in),
        .req    (lane_req),
        .clr    (lane_clr)
    );

    // one lane per color channel
    generate
        for (genvar g = 0; g < noise_filter_pkg::NUM_CHAN; g++) begin : g_lane
            channel_avg_lane u_channel_avg_lane (
                .clk    (clk),
                .arst_n (arst_n),
                .req    (lane_req[g]),
                .clr    (lane_clr),
                .resp   (lane_resp[g])
            );
        end
    endgenerate

    pixel_merge u_pixel_merge (
        .clk     (clk),
        .arst_n  (arst_n),
        .resp    (lane_resp),
        .pix_out (pix_out)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// free-running 100 ns clock from time 0; reset held low for the first 5 rising edges only
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    initial begin
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;          // release just after the 5th edge
    end

endmodule

`default_nettype wire

/* noise_filter_props.sv */
// timing checks assume no vsync rise while a clear is already running
`default_nettype none

module noise_filter_props (
    input logic                          clk,
    input logic                          arst_n,
    input noise_filter_pkg::pix_stream_t pix_in,
    input noise_filter_pkg::pix_result_t pix_out,
    input logic                          clear,
    input logic                          store
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned clr_run;    // consecutive cycles with clear high

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr_run <= 0;
        end else begin
            clr_run <= clear ? clr_run + 1 : 0;
        end
    end

    // feeder, lane and merge registers
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        $past(pix_in.valid, 3) |-> pix_out.valid)
        else $error("input strobe without output strobe 3 cycles later");

    a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
        pix_out.valid |-> $past(pix_in.valid, 3))
        else $error("output strobe without matching input");

    a_filt_valid: assert property (@(posedge clk) disable iff (!arst_n)
        pix_out.filtered |-> pix_out.valid)
        else $error("filtered set on an idle output");

    a_clr_len: assert property (@(posedge clk) disable iff (!arst_n)
        clr_run <= 320)
        else $error("clear ran longer than one line");

    a_clr_store: assert property (@(posedge clk) disable iff (!arst_n)
        !(clear && store))
        else $error("clear and store in the same cycle");

endmodule

bind noise_filter_top noise_filter_props u_noise_filter_props (
    .clk    (clk),
    .arst_n (arst_n),
    .pix_in (pix_in),
    .pix_out(pix_out),
    .clear  (lane_clr.clear),
    .store  (lane_req[0].store)
);

`default_nettype wire

/* noise_filter_tb.sv */
// line model is 1-D like the DUT; tests never raise vsync again while a clear is still running
`default_nettype none

module noise_filter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LEN_RESET   = 10;
    localparam int LEN_ROWS    = 2000;     // clear wait plus five rows
    localparam int LEN_PASS    = 80;
    localparam int LEN_INVALID = 250;
    localparam int LEN_CLEAR   = 420;
    localparam int LEN_GAPS    = 2250;     // 200 bursts of up to 8 plus 3 idle
    localparam int MARGIN      = 1000;
    localparam int TIMEOUT_CYCLES = LEN_RESET + LEN_ROWS + LEN_PASS + LEN_INVALID +
                                    LEN_CLEAR + LEN_GAPS + MARGIN;

    typedef struct packed {
        logic                     filtered;
        noise_filter_pkg::pixel_t pixel;
        int                       cyc;        // drive cycle of the input
    } expect_t;

    logic                          clk;
    logic                          arst_n;
    logic                          en_drv;
    logic                          vs_drv;
    noise_filter_pkg::pix_stream_t pix_drv;
    noise_filter_pkg::pix_result_t pix_out;

    logic                          en_next;
    logic                          vs_next;
    logic                          vs_prev;
    int                            cycle;
    int                            clr_from;
    int                            clr_until;
    int                            err_count;
    int                            check_count;
    int                            in_count;
    int                            out_count;
    noise_filter_pkg::pixel_t      line_ref [noise_filter_pkg::H_PIXELS];
    expect_t                       exp_q [$];

    tb_clock_gen u_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    noise_filter_top u_noise_filter_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .enable  (en_drv),
        .vsync   (vs_drv),
        .pix_in  (pix_drv),
        .pix_out (pix_out)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, got, expected);
            err_count++;
        end
    endtask

    // per channel floor of (a + b) / 2
    function automatic noise_filter_pkg::pixel_t floor_avg(input noise_filter_pkg::pixel_t a,
                                                           input noise_filter_pkg::pixel_t b);
        noise_filter_pkg::pixel_t res;
        int unsigned              ca;
        int unsigned              cb;
        int unsigned              mask;
        res  = '0;
        mask = (1 << noise_filter_pkg::CHAN_W) - 1;
        for (int c = 0; c < noise_filter_pkg::NUM_CHAN; c++) begin
            ca  = (a >> (c * noise_filter_pkg::CHAN_W)) & mask;
            cb  = (b >> (c * noise_filter_pkg::CHAN_W)) & mask;
            res = res | noise_filter_pkg::pixel_t'(((ca + cb) / 2)
                                                   << (c * noise_filter_pkg::CHAN_W));
        end
        return res;
    endfunction

    function automatic noise_filter_pkg::pixel_t rand_pixel();
        return noise_filter_pkg::pixel_t'($urandom);
    endfunction

    // one drive cycle plus the model step for it
    task automatic drive_pixel(input logic valid, input logic active, input int x, input int y,
                               input noise_filter_pkg::pixel_t pix);
        logic                     store;
        logic                     rise;
        noise_filter_pkg::pixel_t left;
        expect_t                  item;
        @(posedge clk);
        #1;
        pix_drv.valid  = valid;
        pix_drv.active = active;
        pix_drv.addr   = {noise_filter_pkg::ypos_t'(y), noise_filter_pkg::xpos_t'(x)};
        pix_drv.pixel  = pix;
        en_drv         = en_next;
        vs_drv         = vs_next;
        rise           = vs_next && !vs_prev;
        vs_prev        = vs_next;
        if (valid) begin
            store = (x < noise_filter_pkg::H_PIXELS) && (y < noise_filter_pkg::V_LINES) &&
                    active && !((cycle >= clr_from) && (cycle <= clr_until));
            item.filtered = store && en_next;
            item.pixel    = pix;
            item.cyc      = cycle;
            if (item.filtered) begin
                left       = (x == 0) ? '0 : line_ref[x-1];
                item.pixel = floor_avg(pix, left);
            end
            if (store) line_ref[x] = pix;
            exp_q.push_back(item);
            in_count++;
        end
        if (rise) begin    // window covers the next 320 drive cycles
            clr_from  = cycle + 1;
            clr_until = cycle + noise_filter_pkg::H_PIXELS;
            foreach (line_ref[i]) line_ref[i] = '0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_pixel(1'b0, 1'b0, 0, 0, '0);
    endtask

    task automatic pulse_vsync();
        vs_next = 1'b1;
        idle_cycles(3);
        vs_next = 1'b0;
        idle_cycles(1);
    endtask

    task automatic drain_pipeline();
        idle_cycles(4);
        while (exp_q.size() != 0) idle_cycles(1);
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %-14s done, %0d mismatches", name, err_count - err_start);
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_count;
        @(posedge clk);
        @(negedge clk);
        check_value("valid in reset", pix_out.valid, 0);
        check_value("filtered in reset", pix_out.filtered, 0);
        @(posedge arst_n);
        repeat (2) @(negedge clk);
        check_value("valid after reset", pix_out.valid, 0);
        check_value("filtered after reset", pix_out.filtered, 0);
        check_value("pixel after reset", pix_out.pixel, 0);
        report_test("reset_state", e0);
    endtask

    task automatic test_filtered_rows();
        int e0;
        int start;
        int len;
        int y;
        e0      = err_count;
        en_next = 1'b1;
        pulse_vsync();
        idle_cycles(noise_filter_pkg::H_PIXELS);
        for (int r = 0; r < 5; r++) begin
            start = (r == 0) ? 0 : $urandom_range(300, 0);
            len   = (r == 0) ? noise_filter_pkg::H_PIXELS : $urandom_range(320 - start, 1);
            y     = $urandom_range(239, 0);
            for (int x = start; x < start + len; x++) drive_pixel(1'b1, 1'b1, x, y, rand_pixel());
            idle_cycles(2);
        end
        drain_pipeline();
        report_test("filtered_rows", e0);
    endtask

    task automatic test_passthrough();
        int e0;
        int base;
        int y;
        e0      = err_count;
        base    = $urandom_range(250, 1);
        y       = $urandom_range(239, 0);
        en_next = 1'b0;
        for (int x = base; x < base + 30; x++) drive_pixel(1'b1, 1'b1, x, y, rand_pixel());
        en_next = 1'b1;    // these read the columns stored while disabled
        for (int x = base + 30; x < base + 40; x++) drive_pixel(1'b1, 1'b1, x, y, rand_pixel());
        repeat (10) drive_pixel(1'b1, 1'b1, base + $urandom_range(29, 1), y, rand_pixel());
        drain_pipeline();
        report_test("passthrough", e0);
    endtask

    task automatic test_invalid();
        int   e0;
        int   kind;
        int   x;
        int   y;
        logic act;
        e0 = err_count;
        for (int i = 0; i < 80; i++) begin
            kind = $urandom_range(3, 0);
            x    = $urandom_range(319, 0);
            y    = $urandom_range(239, 0);
            act  = 1'b1;
            case (kind)
                0: x = $urandom_range(511, 320);
                1: y = $urandom_range(255, 240);
                2: act = 1'b0;
                default: ;
            endcase
            drive_pixel(1'b1, act, x, y, rand_pixel());
            // neighbor still holds the older stored value
            x = (x >= 319) ? $urandom_range(319, 0) : x + 1;
            drive_pixel(1'b1, 1'b1, x, $urandom_range(239, 0), rand_pixel());
            if ($urandom_range(1, 0) == 1) idle_cycles(1);
        end
        drain_pipeline();
        report_test("invalid_pixels", e0);
    endtask

    task automatic test_clear_window();
        int e0;
        e0      = err_count;
        en_next = 1'b1;
        pulse_vsync();
        for (int i = 0; i < 400; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                drive_pixel(1'b1, 1'b1, $urandom_range(319, 0), $urandom_range(239, 0),
                            rand_pixel());
            end else begin
                idle_cycles(1);
            end
        end
        drain_pipeline();
        report_test("clear_window", e0);
    endtask

    task automatic test_strobe_gaps();
        int e0;
        int x;
        int y;
        e0 = err_count;
        x  = 0;
        y  = 0;
        for (int b = 0; b < 200; b++) begin
            en_next = ($urandom_range(3, 0) != 0);
            repeat ($urandom_range(8, 1)) begin    // back-to-back burst
                drive_pixel(1'b1, ($urandom_range(7, 0) != 0), x, y, rand_pixel());
                x = x + 1;
                if (x == noise_filter_pkg::H_PIXELS) begin
                    x = 0;
                    y = (y + 1) % noise_filter_pkg::V_LINES;
                end
            end
            idle_cycles($urandom_range(3, 0));
        end
        drain_pipeline();
        check_value("output count", out_count, in_count);
        report_test("strobe_gaps", e0);
    endtask

    // cycle count and hang guard
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT or the test sequence hung", cycle);
            $display("TB FAILED");
            $finish;
        end
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin : monitor
        expect_t e;
        if (arst_n && pix_out.valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("output strobe at %0t ns with no pixel pending", $time);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                check_value("pixel", pix_out.pixel, e.pixel);
                check_value("filtered", pix_out.filtered, e.filtered);
                check_value("latency", cycle - e.cyc, 3);
            end
        end
    end

    initial begin
        pix_drv     = '0;
        en_drv      = 1'b0;
        vs_drv      = 1'b0;
        en_next     = 1'b0;
        vs_next     = 1'b0;
        vs_prev     = 1'b0;
        cycle       = 0;
        clr_from    = 1;
        clr_until   = 0;    // no window yet
        err_count   = 0;
        check_count = 0;
        in_count    = 0;
        out_count   = 0;
        foreach (line_ref[i]) line_ref[i] = '0;
        void'($urandom(71395));

        test_reset();
        test_filtered_rows();
        test_passthrough();
        test_invalid();
        test_clear_window();
        test_strobe_gaps();

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out of the DUT", exp_q.size());
            err_count++;
        end
        $display("summary: %0d checks, %0d errors, %0d pixels in, %0d pixels out",
                 check_count, err_count, in_count, out_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* noise_filter_top.f */
noise_filter_pkg.sv
pixel_frame_ctrl.sv
channel_avg_lane.sv
pixel_merge.sv
noise_filter_top.sv
tb_clock_gen.sv
noise_filter_props.sv
noise_filter_tb.sv

/* Makefile */
TOP := noise_filter_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f noise_filter_top.f
	@out=$$(./obj_dir/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -qx 'TB PASSED'

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f noise_filter_top.f

clean:
	rm -rf obj_dir
